// ==== xpu_config.svh ====
// byte positions and field widths of the rx mac header path
`ifndef XPU_CONFIG_SVH
`define XPU_CONFIG_SVH

// width of the byte counter coming from the ofdm receiver
`define XPU_BYTE_IDX_W 16

// signal field length width
`define XPU_PKT_LEN_W 16

// frame control plus duration word
`define XPU_FC_W 32

// one station address
`define XPU_MAC_ADDR_W 48

// index of the final byte of each header field
`define XPU_FC_LAST_BYTE 3
`define XPU_ADDR1_LAST_BYTE 9
`define XPU_ADDR2_LAST_BYTE 15
`define XPU_ADDR3_LAST_BYTE 21

`endif

// ==== mac_hdr_pkg.sv ====
// 802.11 mac header types: addresses, frame control word, header and valid pulses
`include "xpu_config.svh"

package mac_hdr_pkg;

    // byte 0 of the address sits in bits 7:0
    typedef logic [`XPU_MAC_ADDR_W-1:0] mac_addr_t;

    typedef enum logic [1:0] {
        mgmt = 2'd0,
        ctrl = 2'd1,
        data = 2'd2,
        ext  = 2'd3
    } frame_type_e;

    // bytes 0 and 1 are frame control, bytes 2 and 3 the duration
    typedef struct packed {
        logic [15:0] duration;
        logic        order;
        logic        protected_frame;
        logic        more_data;
        logic        power_manage;
        logic        retry;
        logic        more_frag;
        logic        from_ds;
        logic        to_ds;
        logic [3:0]  subtype;
        frame_type_e ftype;
        logic [1:0]  version;
    } fc_word_t;

    typedef struct packed {
        fc_word_t  fc;
        mac_addr_t addr1;
        mac_addr_t addr2;
        mac_addr_t addr3;
    } mac_hdr_t;

    // one-cycle pulses, one per field
    typedef struct packed {
        logic fc;
        logic addr1;
        logic addr2;
        logic addr3;
    } hdr_valid_t;

endpackage

// ==== rx_filter_pkg.sv ====
// phy signal field, rx filter configuration and filter result types
`include "xpu_config.svh"

package rx_filter_pkg;

    // header outputs of the ofdm receiver
    typedef struct packed {
        logic                      strobe;
        logic                      valid;
        logic [7:0]                rate;
        logic [`XPU_PKT_LEN_W-1:0] len;
    } phy_sig_t;

    // pass_mask bit 0 mgmt, bit 1 ctrl, bit 2 data
    // ext frames never pass
    typedef struct packed {
        mac_hdr_pkg::mac_addr_t self_mac;
        logic [15:0]            max_len;
        logic [2:0]             pass_mask;
        logic                   promisc;
    } rx_filter_cfg_t;

    // block high keeps the frame away from the processor dma
    typedef struct packed {
        logic block;
        logic valid;
    } filter_res_t;

endpackage

// ==== mac_hdr_parser.sv ====
// mac_hdr_parser: collects fc, addr1, addr2 and addr3 from the receiver byte stream
`timescale 1ns/1ps
`include "xpu_config.svh"

module mac_hdr_parser (
    input  logic                          clk,
    input  logic                          reset_i,
    input  rx_filter_pkg::phy_sig_t       sig_i,
    input  logic [7:0]                    byte_i,
    input  logic                          byte_strobe_i,
    input  logic [`XPU_BYTE_IDX_W-1:0]    byte_idx_i,
    output mac_hdr_pkg::mac_hdr_t         hdr_o,
    output mac_hdr_pkg::hdr_valid_t       hdr_vld_o
);

    // field registers
    logic [`XPU_FC_W-1:0]          fc_q;
    mac_hdr_pkg::mac_addr_t        addr1_q;
    mac_hdr_pkg::mac_addr_t        addr2_q;
    mac_hdr_pkg::mac_addr_t        addr3_q;

    // bit 3 fc, bit 2 addr1, bit 1 addr2, bit 0 addr3
    logic [3:0]                    vld_q;
    logic [3:0]                    done_q;
    logic [3:0]                    last_byte;

    logic                          restart;
    logic                          byte_ok;
    logic                          in_fc;
    logic                          in_addr1;
    logic                          in_addr2;
    logic                          in_addr3;
    logic [`XPU_BYTE_IDX_W-1:0]    off_addr1;
    logic [`XPU_BYTE_IDX_W-1:0]    off_addr2;
    logic [`XPU_BYTE_IDX_W-1:0]    off_addr3;

    always_comb begin
        restart = sig_i.strobe;
        // a byte arriving together with the header strobe is dropped
        byte_ok = byte_strobe_i && !restart;

        in_fc    = (byte_idx_i <= `XPU_FC_LAST_BYTE);
        in_addr1 = (byte_idx_i > `XPU_FC_LAST_BYTE) && (byte_idx_i <= `XPU_ADDR1_LAST_BYTE);
        in_addr2 = (byte_idx_i > `XPU_ADDR1_LAST_BYTE) && (byte_idx_i <= `XPU_ADDR2_LAST_BYTE);
        in_addr3 = (byte_idx_i > `XPU_ADDR2_LAST_BYTE) && (byte_idx_i <= `XPU_ADDR3_LAST_BYTE);

        // byte position inside each address
        off_addr1 = byte_idx_i - `XPU_BYTE_IDX_W'(`XPU_FC_LAST_BYTE + 1);
        off_addr2 = byte_idx_i - `XPU_BYTE_IDX_W'(`XPU_ADDR1_LAST_BYTE + 1);
        off_addr3 = byte_idx_i - `XPU_BYTE_IDX_W'(`XPU_ADDR2_LAST_BYTE + 1);

        last_byte[3] = byte_ok && (byte_idx_i == `XPU_FC_LAST_BYTE);
        last_byte[2] = byte_ok && (byte_idx_i == `XPU_ADDR1_LAST_BYTE);
        last_byte[1] = byte_ok && (byte_idx_i == `XPU_ADDR2_LAST_BYTE);
        last_byte[0] = byte_ok && (byte_idx_i == `XPU_ADDR3_LAST_BYTE);
    end

    always_ff @(posedge clk) begin
        if (reset_i || restart) begin
            fc_q    <= '0;
            addr1_q <= '0;
            addr2_q <= '0;
            addr3_q <= '0;
            vld_q   <= '0;
            done_q  <= '0;
        end else begin
            // one pulse per field and header, repeats of the last byte are ignored
            vld_q  <= last_byte & ~done_q;
            done_q <= done_q | last_byte;

            if (byte_ok) begin
                if (in_fc) begin
                    fc_q[{byte_idx_i[1:0], 3'b000} +: 8] <= byte_i;
                end
                if (in_addr1) begin
                    addr1_q[{off_addr1[2:0], 3'b000} +: 8] <= byte_i;
                end
                if (in_addr2) begin
                    addr2_q[{off_addr2[2:0], 3'b000} +: 8] <= byte_i;
                end
                if (in_addr3) begin
                    addr3_q[{off_addr3[2:0], 3'b000} +: 8] <= byte_i;
                end
            end
        end
    end

    always_comb begin
        hdr_o = '{
            fc:    mac_hdr_pkg::fc_word_t'(fc_q),
            addr1: addr1_q,
            addr2: addr2_q,
            addr3: addr3_q
        };
        hdr_vld_o = mac_hdr_pkg::hdr_valid_t'(vld_q);
    end

    // no field valid stays high for two cycles in a row
    assert property (@(posedge clk) disable iff (reset_i)
        (vld_q & $past(vld_q)) == 4'b0000);

    // the byte stream must deliver frame control before address 1
    assert property (@(posedge clk) disable iff (reset_i)
        vld_q[2] |-> done_q[3]);

endmodule

// ==== rx_frame_filter.sv ====
// self-address match and rx dma block decision per received header
`timescale 1ns/1ps
`include "xpu_config.svh"

module rx_frame_filter (
    input  logic                           clk,
    input  logic                           reset_i,
    input  rx_filter_pkg::phy_sig_t        sig_i,
    input  rx_filter_pkg::rx_filter_cfg_t  cfg_i,
    input  mac_hdr_pkg::mac_hdr_t          hdr_i,
    input  mac_hdr_pkg::hdr_valid_t        hdr_vld_i,
    output rx_filter_pkg::filter_res_t     res_o,
    output logic                           pkt_for_me_o
);

    // length from the last good signal field
    logic [`XPU_PKT_LEN_W-1:0] len_q;

    logic                      self_match;
    logic                      len_ok;
    logic                      type_ok;
    logic                      addr_ok;
    logic                      pass;

    logic                      block_q;
    logic                      valid_q;
    logic                      for_me_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            len_q <= '0;
        end else if (sig_i.strobe && sig_i.valid) begin
            len_q <= sig_i.len;
        end
    end

    always_comb begin
        self_match = (hdr_i.addr1 == cfg_i.self_mac);
        len_ok     = (len_q <= cfg_i.max_len);

        case (hdr_i.fc.ftype)
            mac_hdr_pkg::mgmt: type_ok = cfg_i.pass_mask[0];
            mac_hdr_pkg::ctrl: type_ok = cfg_i.pass_mask[1];
            mac_hdr_pkg::data: type_ok = cfg_i.pass_mask[2];
            default:           type_ok = 1'b0;
        endcase

        // group bit covers broadcast and multicast
        addr_ok = cfg_i.promisc || self_match || hdr_i.addr1[0];
        pass    = len_ok && type_ok && addr_ok;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            block_q  <= 1'b0;
            valid_q  <= 1'b0;
            for_me_q <= 1'b0;
        end else if (sig_i.strobe) begin
            // new frame drops the old decision
            block_q  <= 1'b0;
            valid_q  <= 1'b0;
            for_me_q <= 1'b0;
        end else begin
            valid_q <= hdr_vld_i.addr1;
            if (hdr_vld_i.addr1) begin
                block_q  <= !pass;
                for_me_q <= self_match;
            end
        end
    end

    always_comb begin
        res_o        = '{block: block_q, valid: valid_q};
        pkt_for_me_o = for_me_q;
    end

    // decision comes exactly one cycle after the addr1 pulse of the parser
    assert property (@(posedge clk) disable iff (reset_i)
        res_o.valid |-> $past(hdr_vld_i.addr1));

    // one decision per header
    assert property (@(posedge clk) disable iff (reset_i)
        res_o.valid |=> !res_o.valid);

endmodule

// ==== xpu_rx_top.sv ====
// xpu_rx_top: rx header parser feeding the rx frame filter
`timescale 1ns/1ps
`include "xpu_config.svh"

module xpu_rx_top (
    input  logic                           clk,
    input  logic                           reset_i,
    input  rx_filter_pkg::phy_sig_t        sig_i,
    input  rx_filter_pkg::rx_filter_cfg_t  cfg_i,
    input  logic [7:0]                     byte_i,
    input  logic                           byte_strobe_i,
    input  logic [`XPU_BYTE_IDX_W-1:0]     byte_idx_i,
    output mac_hdr_pkg::mac_hdr_t          hdr_o,
    output mac_hdr_pkg::hdr_valid_t        hdr_vld_o,
    output rx_filter_pkg::filter_res_t     res_o,
    output logic                           pkt_for_me_o
);

    mac_hdr_pkg::mac_hdr_t   hdr;
    mac_hdr_pkg::hdr_valid_t hdr_vld;

    // producer
    mac_hdr_parser mac_hdr_parser_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .sig_i         (sig_i),
        .byte_i        (byte_i),
        .byte_strobe_i (byte_strobe_i),
        .byte_idx_i    (byte_idx_i),
        .hdr_o         (hdr),
        .hdr_vld_o     (hdr_vld)
    );

    // consumer
    rx_frame_filter rx_frame_filter_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .sig_i        (sig_i),
        .cfg_i        (cfg_i),
        .hdr_i        (hdr),
        .hdr_vld_i    (hdr_vld),
        .res_o        (res_o),
        .pkt_for_me_o (pkt_for_me_o)
    );

    assign hdr_o     = hdr;
    assign hdr_vld_o = hdr_vld;

endmodule

// ==== tb_xpu_rx.sv ====
// random frame stimulus, cycle model of the rx header path, compare tasks and checks
`timescale 1ns/1ps
`include "xpu_config.svh"

module tb_xpu_rx;

    logic                          clk;
    logic                          reset_i;
    rx_filter_pkg::phy_sig_t       sig_i;
    rx_filter_pkg::rx_filter_cfg_t cfg_i;
    logic [7:0]                    byte_i;
    logic                          byte_strobe_i;
    logic [`XPU_BYTE_IDX_W-1:0]    byte_idx_i;
    mac_hdr_pkg::mac_hdr_t         hdr_o;
    mac_hdr_pkg::hdr_valid_t       hdr_vld_o;
    rx_filter_pkg::filter_res_t    res_o;
    logic                          pkt_for_me_o;

    // expected state updated on the rising edge
    logic [7:0]                    exp_bytes [0:21];
    mac_hdr_pkg::mac_hdr_t         exp_hdr;
    mac_hdr_pkg::hdr_valid_t       exp_vld;
    rx_filter_pkg::filter_res_t    exp_res;
    logic                          exp_for_me;
    logic [`XPU_PKT_LEN_W-1:0]     exp_len;

    // stimulus state
    rx_filter_pkg::rx_filter_cfg_t cur_cfg;
    logic [7:0]                    frame_bytes [0:25];
    logic [15:0]                   hdr_len;
    logic                          checking;
    logic                          seen_res;
    logic                          seen_addr3;
    logic                          aborted;
    int                            n_bytes;
    int                            n_blocked;
    int                            n_passed;
    int                            n_for_me;
    int                            n_aborted;

    xpu_rx_top UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .sig_i         (sig_i),
        .cfg_i         (cfg_i),
        .byte_i        (byte_i),
        .byte_strobe_i (byte_strobe_i),
        .byte_idx_i    (byte_idx_i),
        .hdr_o         (hdr_o),
        .hdr_vld_o     (hdr_vld_o),
        .res_o         (res_o),
        .pkt_for_me_o  (pkt_for_me_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_hdr(input string name, input mac_hdr_pkg::mac_hdr_t exp,
                             input mac_hdr_pkg::mac_hdr_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_vld(input string name, input mac_hdr_pkg::hdr_valid_t exp,
                             input mac_hdr_pkg::hdr_valid_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_res(input string name, input rx_filter_pkg::filter_res_t exp,
                             input rx_filter_pkg::filter_res_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // header assembled byte by byte from the stream with byte 0 lowest
    function automatic mac_hdr_pkg::mac_hdr_t assemble_hdr();
        mac_hdr_pkg::mac_hdr_t h;
        int k;
        h.fc = mac_hdr_pkg::fc_word_t'({exp_bytes[3], exp_bytes[2], exp_bytes[1], exp_bytes[0]});
        for (k = 0; k < 6; k++) begin
            h.addr1[8*k +: 8] = exp_bytes[4 + k];
            h.addr2[8*k +: 8] = exp_bytes[10 + k];
            h.addr3[8*k +: 8] = exp_bytes[16 + k];
        end
        return h;
    endfunction

    function automatic logic frame_passes(input mac_hdr_pkg::mac_hdr_t h,
                                          input rx_filter_pkg::rx_filter_cfg_t c,
                                          input logic [15:0] len);
        logic len_ok;
        logic type_ok;
        logic addr_ok;
        len_ok = (len <= c.max_len);
        if (h.fc.ftype == mac_hdr_pkg::ext) begin
            type_ok = 1'b0;
        end else begin
            type_ok = c.pass_mask[h.fc.ftype];
        end
        addr_ok = c.promisc || (h.addr1 == c.self_mac) || h.addr1[0];
        return len_ok && type_ok && addr_ok;
    endfunction

    // reference model sees the same input values as the DUT at each edge
    always @(posedge clk) begin
        if (reset_i) begin
            foreach (exp_bytes[k]) begin
                exp_bytes[k] = 8'h00;
            end
            exp_vld    = '0;
            exp_res    = '0;
            exp_for_me = 1'b0;
            exp_len    = '0;
        end else begin
            // filter first since it works on the header of the previous cycle
            if (sig_i.strobe) begin
                exp_res    = '0;
                exp_for_me = 1'b0;
            end else begin
                exp_res.valid = exp_vld.addr1;
                if (exp_vld.addr1) begin
                    exp_res.block = !frame_passes(exp_hdr, cfg_i, exp_len);
                    exp_for_me    = (exp_hdr.addr1 == cfg_i.self_mac);
                end
            end
            if (sig_i.strobe && sig_i.valid) begin
                exp_len = sig_i.len;
            end

            exp_vld = '0;
            if (sig_i.strobe) begin
                foreach (exp_bytes[k]) begin
                    exp_bytes[k] = 8'h00;
                end
            end else if (byte_strobe_i) begin
                if (byte_idx_i <= `XPU_ADDR3_LAST_BYTE) begin
                    exp_bytes[byte_idx_i] = byte_i;
                end
                exp_vld.fc    = (byte_idx_i == `XPU_FC_LAST_BYTE);
                exp_vld.addr1 = (byte_idx_i == `XPU_ADDR1_LAST_BYTE);
                exp_vld.addr2 = (byte_idx_i == `XPU_ADDR2_LAST_BYTE);
                exp_vld.addr3 = (byte_idx_i == `XPU_ADDR3_LAST_BYTE);
            end
        end
        exp_hdr = assemble_hdr();
    end

    // outputs compared every cycle on the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_vld("hdr_vld_o", exp_vld, hdr_vld_o);
            check_hdr("hdr_o", exp_hdr, hdr_o);
            check_res("res_o", exp_res, res_o);
            check_bit("pkt_for_me_o", exp_for_me, pkt_for_me_o);
            if (hdr_vld_o.addr3) begin
                seen_addr3 = 1'b1;
            end
            if (res_o.valid) begin
                seen_res = 1'b1;
                if (res_o.block) begin
                    n_blocked++;
                end else begin
                    n_passed++;
                end
                if (pkt_for_me_o) begin
                    n_for_me++;
                end
            end
        end
    end

    task automatic idle_cycle();
        @(posedge clk);
        sig_i.strobe  <= 1'b0;
        byte_strobe_i <= 1'b0;
        byte_i        <= 8'($urandom);
        byte_idx_i    <= `XPU_BYTE_IDX_W'($urandom % 32);
    endtask

    task automatic send_byte(input int idx, input logic [7:0] val);
        int gap;
        gap = $urandom % 4;
        repeat (gap) idle_cycle();
        @(posedge clk);
        sig_i.strobe  <= 1'b0;
        byte_strobe_i <= 1'b1;
        byte_i        <= val;
        byte_idx_i    <= `XPU_BYTE_IDX_W'(idx);
    endtask

    task automatic send_hdr_strobe(input logic valid, input logic [15:0] len);
        @(posedge clk);
        sig_i.strobe  <= 1'b1;
        sig_i.valid   <= valid;
        sig_i.rate    <= 8'($urandom);
        sig_i.len     <= len;
        // sometimes a byte in the same cycle which the parser must drop
        byte_strobe_i <= (($urandom % 4) == 0);
        byte_i        <= 8'($urandom);
        byte_idx_i    <= `XPU_BYTE_IDX_W'($urandom % 22);
    endtask

    task automatic new_config();
        if (($urandom % 4) == 0) begin
            cur_cfg.self_mac = {16'($urandom), 32'($urandom)} & ~48'h1;
        end
        cur_cfg.max_len   = 16'(64 + $urandom % 2000);
        cur_cfg.pass_mask = 3'($urandom);
        cur_cfg.promisc   = (($urandom % 4) == 0);
        @(posedge clk);
        cfg_i         <= cur_cfg;
        sig_i.strobe  <= 1'b0;
        byte_strobe_i <= 1'b0;
    endtask

    // addr1 is own, broadcast or random so every filter path shows up
    task automatic build_frame();
        mac_hdr_pkg::mac_addr_t a1;
        int k;
        for (k = 0; k < 26; k++) begin
            frame_bytes[k] = 8'($urandom);
        end
        case ($urandom % 4)
            0:       a1 = cur_cfg.self_mac;
            1:       a1 = '1;
            default: a1 = {16'($urandom), 32'($urandom)};
        endcase
        for (k = 0; k < 6; k++) begin
            frame_bytes[4 + k] = a1[8*k +: 8];
        end
        hdr_len = cur_cfg.max_len + 16'($urandom % 41) - 16'd20;
    endtask

    task automatic wait_frame_done();
        int n;
        n = 0;
        while (!(seen_res && seen_addr3)) begin
            if (n >= 50) begin
                if (!seen_res) begin
                    $display("timeout at %0t: res_o.valid pulse never came", $time);
                end else begin
                    $display("timeout at %0t: hdr_vld_o.addr3 pulse never came", $time);
                end
                end_with_failure();
            end else begin
                idle_cycle();
                n++;
            end
        end
    endtask

    initial begin
        void'($urandom(4));
        checking      = 1'b0;
        seen_res      = 1'b0;
        seen_addr3    = 1'b0;
        n_blocked     = 0;
        n_passed      = 0;
        n_for_me      = 0;
        n_aborted     = 0;
        reset_i       = 1'b1;
        sig_i         = '0;
        byte_i        = 8'h00;
        byte_strobe_i = 1'b0;
        byte_idx_i    = '0;
        cur_cfg       = '0;
        cur_cfg.self_mac  = {16'($urandom), 32'($urandom)} & ~48'h1;
        cur_cfg.max_len   = 16'd1500;
        cur_cfg.pass_mask = 3'b111;
        cfg_i         = cur_cfg;

        repeat (5) @(posedge clk);
        reset_i  <= 1'b0;
        checking = 1'b1;

        // quiet state straight after reset
        @(negedge clk);
        check_vld("hdr_vld_o after reset", '0, hdr_vld_o);
        check_bit("res_o.block after reset", 1'b0, res_o.block);
        check_bit("pkt_for_me_o after reset", 1'b0, pkt_for_me_o);

        for (int frame = 0; frame < 300; frame++) begin
            seen_res   = 1'b0;
            seen_addr3 = 1'b0;
            new_config();
            build_frame();
            send_hdr_strobe((($urandom % 8) != 0), hdr_len);
            aborted = (($urandom % 10) == 0);
            if (aborted) begin
                n_bytes = 1 + $urandom % 21;
            end else begin
                n_bytes = 22 + $urandom % 4;
            end
            for (int i = 0; i < n_bytes; i++) begin
                send_byte(i, frame_bytes[i]);
            end
            if (aborted) begin
                // restart in mid header drops the partial fields
                repeat ($urandom % 4) idle_cycle();
                send_hdr_strobe(1'($urandom), 16'($urandom));
                n_aborted++;
            end else begin
                wait_frame_done();
            end
        end
        repeat (3) idle_cycle();

        $display("frames 300 aborted %0d blocked %0d passed %0d for me %0d",
                 n_aborted, n_blocked, n_passed, n_for_me);
        if (n_blocked == 0 || n_passed == 0 || n_for_me == 0) begin
            $display("a filter outcome never occurred in the random frames");
            end_with_failure();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+.
mac_hdr_pkg.sv
rx_filter_pkg.sv
mac_hdr_parser.sv
rx_frame_filter.sv
xpu_rx_top.sv
tb_xpu_rx.sv

// ==== Bender.yml ====
package:
  name: xpu_rx

export_include_dirs:
  - .

sources:
  - files:
      - mac_hdr_pkg.sv
      - rx_filter_pkg.sv
      - mac_hdr_parser.sv
      - rx_frame_filter.sv
      - xpu_rx_top.sv
  - target: test
    files:
      - tb_xpu_rx.sv
